/* design/ddl_pkg.sv */
`default_nettype none

package ddl_pkg;

  // Address, bank and data widths
  localparam int ROW_BITS  = 13;
  localparam int BANK_BITS = 3;
  localparam int DATA_BITS = 32;
  localparam int MASK_BITS = 4;

  // DDR3 commands, encoded as {RAS#, CAS#, WE#}
  typedef enum logic [2:0] {
    CMD_MODE = 3'b000,
    CMD_REFR = 3'b001,
    CMD_PREC = 3'b010,
    CMD_ACTV = 3'b011,
    CMD_WRIT = 3'b100,
    CMD_READ = 3'b101,
    CMD_ZQCL = 3'b110,
    CMD_NOOP = 3'b111
  } cmd_e;

  // The same word seen as a command code or as the three PHY strobes
  typedef union packed {
    cmd_e code;
    struct packed {
      logic ras_n;
      logic cas_n;
      logic we_n;
    } bits;
  } cmd_u;

  // Bank-machine states, named after the last accepted command
  typedef enum logic [2:0] {
    ST_IDLE = 3'd0,
    ST_ACTV = 3'd1,
    ST_READ = 3'd2,
    ST_WRIT = 3'd3,
    ST_PREC = 3'd4,
    ST_REFR = 3'd5,
    ST_MODE = 3'd6,
    ST_ZQCL = 3'd7
  } state_e;

  // Cycles from acceptance until ready is high again
  localparam int CYC_ACT_TO_RW  = 3;
  localparam int CYC_ACT_TO_ACT = 4;
  localparam int CYC_PRE_TO_ACT = 3;
  localparam int CYC_REF_TO_ACT = 11;
  localparam int CYC_MRD        = 4;
  localparam int CYC_ZQ_INIT    = 64;
  localparam int CYC_RD_TO_RD   = 4;
  localparam int CYC_RD_TO_WR   = 6;
  localparam int CYC_WR_TO_RD   = 9;
  localparam int CYC_WR_TO_WR   = 4;
  localparam int CYC_RW_TO_ACT  = 2;
  localparam int CYC_RW_TO_PRE  = 4;

  // Write latency to the strobe, and BL8 burst length in clock cycles
  localparam int WR_LAT    = 3;
  localparam int BURST_CYC = 4;

  // The hold-off timer counts down from N-1, so ZQ init sets the width
  localparam int TIMER_BITS = $clog2(CYC_ZQ_INIT);

endpackage

`default_nettype wire

/* design/ddl_cmd_issue.sv */
`default_nettype none
`timescale 1ns/100ps

module ddl_cmd_issue (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            ctl_req_i,
  input  ddl_pkg::cmd_e                   ctl_cmd_i,
  input  logic [ddl_pkg::BANK_BITS-1:0]   ctl_ba_i,
  input  logic [ddl_pkg::ROW_BITS-1:0]    ctl_adr_i,
  output logic                            ctl_rdy_o,
  output ddl_pkg::cmd_u                   dfi_cmd_o,
  output logic [ddl_pkg::BANK_BITS-1:0]   dfi_bank_o,
  output logic [ddl_pkg::ROW_BITS-1:0]    dfi_addr_o,
  output logic                            wr_accept_o
);

  ddl_pkg::state_e                  state_q;
  ddl_pkg::state_e                  nxt_state;
  ddl_pkg::cmd_u                    cmd_q;
  logic [ddl_pkg::BANK_BITS-1:0]    ba_q;
  logic [ddl_pkg::ROW_BITS-1:0]     adr_q;
  logic [ddl_pkg::TIMER_BITS-1:0]   timer_q;
  logic                             rdy_q;
  logic                             accept;
  logic                             legal;
  int                               hold_cyc;
  int                               hold_last;

  assign accept      = ctl_req_i & rdy_q;
  assign wr_accept_o = accept & (ctl_cmd_i == ddl_pkg::CMD_WRIT);
  assign hold_last   = hold_cyc - 1;

  // Hold-off for each legal (state, command) pair
  always_comb begin
    hold_cyc = 1;
    legal    = 1'b1;
    case (state_q)
      ddl_pkg::ST_IDLE: begin
        case (ctl_cmd_i)
          ddl_pkg::CMD_ACTV: hold_cyc = ddl_pkg::CYC_ACT_TO_RW;
          ddl_pkg::CMD_PREC: hold_cyc = ddl_pkg::CYC_PRE_TO_ACT;
          ddl_pkg::CMD_REFR: hold_cyc = ddl_pkg::CYC_REF_TO_ACT;
          ddl_pkg::CMD_MODE: hold_cyc = ddl_pkg::CYC_MRD;
          ddl_pkg::CMD_ZQCL: hold_cyc = ddl_pkg::CYC_ZQ_INIT;
          default: legal = 1'b0;
        endcase
      end
      ddl_pkg::ST_ACTV: begin
        case (ctl_cmd_i)
          ddl_pkg::CMD_READ: hold_cyc = ddl_pkg::CYC_RD_TO_RD;
          ddl_pkg::CMD_WRIT: hold_cyc = ddl_pkg::CYC_WR_TO_WR;
          ddl_pkg::CMD_ACTV: hold_cyc = ddl_pkg::CYC_ACT_TO_ACT;
          default: legal = 1'b0;
        endcase
      end
      ddl_pkg::ST_READ: begin
        case (ctl_cmd_i)
          ddl_pkg::CMD_READ: hold_cyc = ddl_pkg::CYC_RD_TO_RD;
          ddl_pkg::CMD_WRIT: hold_cyc = ddl_pkg::CYC_RD_TO_WR;
          ddl_pkg::CMD_ACTV: hold_cyc = ddl_pkg::CYC_RW_TO_ACT;
          ddl_pkg::CMD_PREC: hold_cyc = ddl_pkg::CYC_RW_TO_PRE;
          default: legal = 1'b0;
        endcase
      end
      ddl_pkg::ST_WRIT: begin
        case (ctl_cmd_i)
          ddl_pkg::CMD_WRIT: hold_cyc = ddl_pkg::CYC_WR_TO_WR;
          ddl_pkg::CMD_READ: hold_cyc = ddl_pkg::CYC_WR_TO_RD;
          ddl_pkg::CMD_ACTV: hold_cyc = ddl_pkg::CYC_RW_TO_ACT;
          ddl_pkg::CMD_PREC: hold_cyc = ddl_pkg::CYC_RW_TO_PRE;
          default: legal = 1'b0;
        endcase
      end
      ddl_pkg::ST_PREC: begin
        case (ctl_cmd_i)
          ddl_pkg::CMD_ACTV: hold_cyc = ddl_pkg::CYC_PRE_TO_ACT;
          ddl_pkg::CMD_REFR: hold_cyc = ddl_pkg::CYC_REF_TO_ACT;
          default: legal = 1'b0;
        endcase
      end
      ddl_pkg::ST_REFR: begin
        case (ctl_cmd_i)
          ddl_pkg::CMD_ACTV: hold_cyc = ddl_pkg::CYC_ACT_TO_RW;
          ddl_pkg::CMD_REFR: hold_cyc = ddl_pkg::CYC_REF_TO_ACT;
          ddl_pkg::CMD_PREC: hold_cyc = ddl_pkg::CYC_PRE_TO_ACT;
          default: legal = 1'b0;
        endcase
      end
      ddl_pkg::ST_MODE: begin
        case (ctl_cmd_i)
          ddl_pkg::CMD_MODE: hold_cyc = ddl_pkg::CYC_MRD;
          ddl_pkg::CMD_PREC: hold_cyc = ddl_pkg::CYC_PRE_TO_ACT;
          ddl_pkg::CMD_REFR: hold_cyc = ddl_pkg::CYC_REF_TO_ACT;
          ddl_pkg::CMD_ZQCL: hold_cyc = ddl_pkg::CYC_ZQ_INIT;
          default: legal = 1'b0;
        endcase
      end
      default: begin
        // ZQ calibration done, bank is closed
        case (ctl_cmd_i)
          ddl_pkg::CMD_ACTV: hold_cyc = ddl_pkg::CYC_ACT_TO_RW;
          ddl_pkg::CMD_REFR: hold_cyc = ddl_pkg::CYC_REF_TO_ACT;
          ddl_pkg::CMD_PREC: hold_cyc = ddl_pkg::CYC_PRE_TO_ACT;
          default: legal = 1'b0;
        endcase
      end
    endcase
  end

  // New state is named after the accepted command
  always_comb begin
    case (ctl_cmd_i)
      ddl_pkg::CMD_ACTV: nxt_state = ddl_pkg::ST_ACTV;
      ddl_pkg::CMD_READ: nxt_state = ddl_pkg::ST_READ;
      ddl_pkg::CMD_WRIT: nxt_state = ddl_pkg::ST_WRIT;
      ddl_pkg::CMD_PREC: nxt_state = ddl_pkg::ST_PREC;
      ddl_pkg::CMD_REFR: nxt_state = ddl_pkg::ST_REFR;
      ddl_pkg::CMD_MODE: nxt_state = ddl_pkg::ST_MODE;
      ddl_pkg::CMD_ZQCL: nxt_state = ddl_pkg::ST_ZQCL;
      default:           nxt_state = ddl_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q    <= ddl_pkg::ST_IDLE;
      rdy_q      <= 1'b1;
      timer_q    <= '0;
      cmd_q.code <= ddl_pkg::CMD_NOOP;
    end else begin
      // Command is on the PHY bus for exactly one cycle
      cmd_q.code <= accept ? ctl_cmd_i : ddl_pkg::CMD_NOOP;
      if (accept) begin
        state_q <= nxt_state;
        rdy_q   <= 1'b0;
        timer_q <= hold_last[ddl_pkg::TIMER_BITS-1:0];
      end else if (!rdy_q) begin
        // One down-counter serves every hold-off, ZQ calibration included
        if (timer_q == '0) begin
          rdy_q <= 1'b1;
        end else begin
          timer_q <= timer_q - 1'b1;
        end
      end else begin
        state_q <= ddl_pkg::ST_IDLE;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      ba_q  <= ctl_ba_i;
      adr_q <= ctl_adr_i;
    end
  end

  assign ctl_rdy_o  = rdy_q;
  assign dfi_cmd_o  = cmd_q;
  assign dfi_bank_o = ba_q;
  assign dfi_addr_o = adr_q;

  a_legal_cmd: assert property (@(posedge clock) disable iff (reset)
    accept |-> legal);

  // A pending request keeps its command, bank and address until accepted
  a_req_stable: assert property (@(posedge clock) disable iff (reset)
    ctl_req_i && !ctl_rdy_o |=> ctl_req_i && $stable(ctl_cmd_i)
      && $stable(ctl_ba_i) && $stable(ctl_adr_i));

endmodule

`default_nettype wire

/* design/ddl_write_path.sv */
`default_nettype none
`timescale 1ns/100ps

module ddl_write_path (
  input  logic clock,
  input  logic reset,
  input  logic wr_accept_i,
  output logic dfi_wstb_o,
  output logic dfi_wren_o
);

  // Write latency line with one bit per accepted WRITE in flight
  logic [ddl_pkg::WR_LAT-1:0]    lat_q;
  logic                          wstb_q;
  // Write-enable window whose bit 0 drives the PHY
  logic [ddl_pkg::BURST_CYC-1:0] burst_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      lat_q   <= '0;
      wstb_q  <= 1'b0;
      burst_q <= '0;
    end else begin
      lat_q <= {lat_q[ddl_pkg::WR_LAT-2:0], wr_accept_i};

      // Strobe leaves WR_LAT cycles after the accept edge
      wstb_q <= lat_q[ddl_pkg::WR_LAT-1];

      // A strobe (re)fills the window, so a following burst runs on seamlessly
      if (wstb_q) begin
        burst_q <= {ddl_pkg::BURST_CYC{1'b1}};
      end else begin
        burst_q <= {1'b0, burst_q[ddl_pkg::BURST_CYC-1:1]};
      end
    end
  end

  assign dfi_wstb_o = wstb_q;
  assign dfi_wren_o = burst_q[0];

endmodule

`default_nettype wire

/* design/ddr3_ddl.sv */
`default_nettype none
`timescale 1ns/100ps

module ddr3_ddl (
  input  logic                            clock,
  input  logic                            reset,

  // Memory controller command port
  input  logic                            ctl_req_i,
  output logic                            ctl_rdy_o,
  input  ddl_pkg::cmd_e                   ctl_cmd_i,
  input  logic [ddl_pkg::BANK_BITS-1:0]   ctl_ba_i,
  input  logic [ddl_pkg::ROW_BITS-1:0]    ctl_adr_i,

  // Write data port
  input  logic                            mem_wvalid_i,
  output logic                            mem_wready_o,
  input  logic [ddl_pkg::MASK_BITS-1:0]   mem_wrmask_i,
  input  logic [ddl_pkg::DATA_BITS-1:0]   mem_wrdata_i,

  // Read data port
  output logic                            mem_rvalid_o,
  input  logic                            mem_rready_i,
  output logic [ddl_pkg::DATA_BITS-1:0]   mem_rddata_o,

  // PHY side
  output logic                            dfi_ras_no,
  output logic                            dfi_cas_no,
  output logic                            dfi_we_no,
  output logic [ddl_pkg::BANK_BITS-1:0]   dfi_bank_o,
  output logic [ddl_pkg::ROW_BITS-1:0]    dfi_addr_o,
  output logic                            dfi_wstb_o,
  output logic                            dfi_wren_o,
  output logic [ddl_pkg::MASK_BITS-1:0]   dfi_mask_o,
  output logic [ddl_pkg::DATA_BITS-1:0]   dfi_data_o,
  input  logic                            dfi_rvld_i,
  input  logic [ddl_pkg::DATA_BITS-1:0]   dfi_data_i
);

  ddl_pkg::cmd_u dfi_cmd;
  logic          wr_accept;

  ddl_cmd_issue i_cmd_issue (
    .clock       (clock),
    .reset       (reset),
    .ctl_req_i   (ctl_req_i),
    .ctl_cmd_i   (ctl_cmd_i),
    .ctl_ba_i    (ctl_ba_i),
    .ctl_adr_i   (ctl_adr_i),
    .ctl_rdy_o   (ctl_rdy_o),
    .dfi_cmd_o   (dfi_cmd),
    .dfi_bank_o  (dfi_bank_o),
    .dfi_addr_o  (dfi_addr_o),
    .wr_accept_o (wr_accept)
  );

  ddl_write_path i_write_path (
    .clock       (clock),
    .reset       (reset),
    .wr_accept_i (wr_accept),
    .dfi_wstb_o  (dfi_wstb_o),
    .dfi_wren_o  (dfi_wren_o)
  );

  // Registered command word goes out as the three active-low strobes
  assign dfi_ras_no = dfi_cmd.bits.ras_n;
  assign dfi_cas_no = dfi_cmd.bits.cas_n;
  assign dfi_we_no  = dfi_cmd.bits.we_n;

  // Write data is taken by the PHY while the write-enable window is open
  assign mem_wready_o = dfi_wren_o;
  assign dfi_mask_o   = mem_wrmask_i;
  assign dfi_data_o   = mem_wrdata_i;

  // Read data has no buffering here
  assign mem_rvalid_o = dfi_rvld_i;
  assign mem_rddata_o = dfi_data_i;

  // The controller must sink every read beat the PHY returns
  a_read_ready: assert property (@(posedge clock) disable iff (reset)
    mem_rvalid_o |-> mem_rready_i);

  // Window opened WR_LAT cycles after a WRITE, and data must be ready by then
  a_write_valid: assert property (@(posedge clock) disable iff (reset)
    dfi_wren_o |-> mem_wvalid_i);

endmodule

`default_nettype wire

/* tb/ddl_checker.sv */
`default_nettype none
`timescale 1ns/100ps

module ddl_checker (
  input  logic                            clock,
  input  logic                            reset,
  input  int                              test_id_i,
  input  logic                            test_end_i,
  // Controller side of the DUT
  input  logic                            req_i,
  input  logic                            rdy_i,
  input  ddl_pkg::cmd_e                   cmd_i,
  input  logic [ddl_pkg::BANK_BITS-1:0]   ba_i,
  input  logic [ddl_pkg::ROW_BITS-1:0]    adr_i,
  input  logic                            wready_i,
  input  logic [ddl_pkg::DATA_BITS-1:0]   wrdata_i,
  input  logic [ddl_pkg::MASK_BITS-1:0]   wrmask_i,
  input  logic                            rvalid_i,
  input  logic [ddl_pkg::DATA_BITS-1:0]   rddata_i,
  // PHY side of the DUT
  input  logic                            ras_n_i,
  input  logic                            cas_n_i,
  input  logic                            we_n_i,
  input  logic [ddl_pkg::BANK_BITS-1:0]   bank_i,
  input  logic [ddl_pkg::ROW_BITS-1:0]    addr_i,
  input  logic                            wstb_i,
  input  logic                            wren_i,
  input  logic [ddl_pkg::MASK_BITS-1:0]   phy_mask_i,
  input  logic [ddl_pkg::DATA_BITS-1:0]   phy_data_i,
  input  logic                            phy_rvld_i,
  input  logic [ddl_pkg::DATA_BITS-1:0]   phy_rdata_i,
  output int                              checks_o,
  output int                              errors_o
);

  // Bank state of the model where NOOP stands for the idle bank
  ddl_pkg::cmd_e                  bank_st;
  ddl_pkg::cmd_e                  exp_cmd;
  logic [ddl_pkg::BANK_BITS-1:0]  exp_ba;
  logic [ddl_pkg::ROW_BITS-1:0]   exp_adr;
  logic                           exp_rdy;
  int                             hold_left;
  int                             hold_n;
  // Bit k is the expected level k cycles after the current one
  logic [15:0]                    wstb_plan;
  logic [15:0]                    wren_plan;
  logic                           armed;
  int                             checks;
  int                             errors;
  int                             test_errs;

  assign checks_o = checks;
  assign errors_o = errors;

  initial begin
    armed     = 1'b0;
    checks    = 0;
    errors    = 0;
    test_errs = 0;
  end

  function automatic string test_name(input int id);
    case (id)
      0:       return "reset_values";
      1:       return "table_walk";
      2:       return "random_mixed";
      3:       return "random_gaps";
      default: return "unknown";
    endcase
  endfunction

  // Cycles until ready again or 0 for a command this state does not allow
  function automatic int hold_for(input ddl_pkg::cmd_e st, input ddl_pkg::cmd_e c);
    int n;
    n = 0;
    case (c)
      ddl_pkg::CMD_ACTV: begin
        case (st)
          ddl_pkg::CMD_NOOP, ddl_pkg::CMD_REFR, ddl_pkg::CMD_ZQCL: n = ddl_pkg::CYC_ACT_TO_RW;
          ddl_pkg::CMD_ACTV: n = ddl_pkg::CYC_ACT_TO_ACT;
          ddl_pkg::CMD_READ, ddl_pkg::CMD_WRIT: n = ddl_pkg::CYC_RW_TO_ACT;
          ddl_pkg::CMD_PREC: n = ddl_pkg::CYC_PRE_TO_ACT;
          default: n = 0;
        endcase
      end
      ddl_pkg::CMD_READ: begin
        if (st == ddl_pkg::CMD_ACTV || st == ddl_pkg::CMD_READ) n = ddl_pkg::CYC_RD_TO_RD;
        else if (st == ddl_pkg::CMD_WRIT) n = ddl_pkg::CYC_WR_TO_RD;
      end
      ddl_pkg::CMD_WRIT: begin
        if (st == ddl_pkg::CMD_ACTV || st == ddl_pkg::CMD_WRIT) n = ddl_pkg::CYC_WR_TO_WR;
        else if (st == ddl_pkg::CMD_READ) n = ddl_pkg::CYC_RD_TO_WR;
      end
      ddl_pkg::CMD_PREC: begin
        case (st)
          ddl_pkg::CMD_NOOP, ddl_pkg::CMD_REFR, ddl_pkg::CMD_MODE, ddl_pkg::CMD_ZQCL:
            n = ddl_pkg::CYC_PRE_TO_ACT;
          ddl_pkg::CMD_READ, ddl_pkg::CMD_WRIT: n = ddl_pkg::CYC_RW_TO_PRE;
          default: n = 0;
        endcase
      end
      ddl_pkg::CMD_REFR: begin
        case (st)
          ddl_pkg::CMD_NOOP, ddl_pkg::CMD_PREC, ddl_pkg::CMD_REFR, ddl_pkg::CMD_MODE,
          ddl_pkg::CMD_ZQCL: n = ddl_pkg::CYC_REF_TO_ACT;
          default: n = 0;
        endcase
      end
      ddl_pkg::CMD_MODE: begin
        if (st == ddl_pkg::CMD_NOOP || st == ddl_pkg::CMD_MODE) n = ddl_pkg::CYC_MRD;
      end
      ddl_pkg::CMD_ZQCL: begin
        if (st == ddl_pkg::CMD_NOOP || st == ddl_pkg::CMD_MODE) n = ddl_pkg::CYC_ZQ_INIT;
      end
      default: n = 0;
    endcase
    return n;
  endfunction

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks = checks + 1;
    if (exp !== act) begin
      errors    = errors + 1;
      test_errs = test_errs + 1;
      $display("mismatch %s %s: expected %h, actual %h", test_name(test_id_i), what, exp, act);
    end
  endtask

  always @(posedge clock) begin
    if (reset) begin
      armed     = 1'b1;
      bank_st   = ddl_pkg::CMD_NOOP;
      exp_cmd   = ddl_pkg::CMD_NOOP;
      exp_rdy   = 1'b1;
      hold_left = 0;
      wstb_plan = '0;
      wren_plan = '0;
    end else if (armed) begin
      // Cycle that ends at this edge
      compare("ready", exp_rdy, rdy_i);
      compare("dfi command", exp_cmd, {ras_n_i, cas_n_i, we_n_i});
      if (exp_cmd != ddl_pkg::CMD_NOOP) begin
        compare("dfi bank", exp_ba, bank_i);
        compare("dfi address", exp_adr, addr_i);
      end
      compare("write strobe", wstb_plan[0], wstb_i);
      compare("write enable", wren_plan[0], wren_i);
      compare("write ready", wren_plan[0], wready_i);
      if (wren_plan[0]) begin
        compare("write data", wrdata_i, phy_data_i);
        compare("write mask", wrmask_i, phy_mask_i);
      end
      compare("read valid", phy_rvld_i, rvalid_i);
      compare("read data", phy_rdata_i, rddata_i);

      // Expectations for the next cycle
      wstb_plan = wstb_plan >> 1;
      wren_plan = wren_plan >> 1;
      if (req_i && exp_rdy) begin
        hold_n = hold_for(bank_st, cmd_i);
        if (hold_n == 0) begin
          errors    = errors + 1;
          test_errs = test_errs + 1;
          $display("error %s: %s accepted in bank state %s, which does not allow it",
                   test_name(test_id_i), cmd_i.name(), bank_st.name());
        end
        exp_cmd   = cmd_i;
        exp_ba    = ba_i;
        exp_adr   = adr_i;
        bank_st   = cmd_i;
        exp_rdy   = 1'b0;
        hold_left = hold_n;
        if (cmd_i == ddl_pkg::CMD_WRIT) begin
          wstb_plan[ddl_pkg::WR_LAT] = 1'b1;
          for (int k = 1; k <= ddl_pkg::BURST_CYC; k++) begin
            wren_plan[ddl_pkg::WR_LAT + k] = 1'b1;
          end
        end
      end else begin
        exp_cmd = ddl_pkg::CMD_NOOP;
        if (exp_rdy) begin
          bank_st = ddl_pkg::CMD_NOOP;
        end else begin
          hold_left = hold_left - 1;
          if (hold_left <= 0) exp_rdy = 1'b1;
        end
      end

      if (test_end_i) begin
        $display("test %s done, %0d errors", test_name(test_id_i), test_errs);
        test_errs = 0;
      end
    end
  end

endmodule

`default_nettype wire

/* tb/tb_ddl.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_ddl;

  localparam logic [31:0] SEED = 32'ha1da_1d48;
  localparam int MIXED_CMDS = 600;
  localparam int GAP_CMDS   = 200;
  localparam int MAX_GAP    = 8;
  // The table walk holds fewer than this many commands
  localparam int WALK_MAX   = 48;
  // Worst case per command is the ZQ hold-off plus the longest idle gap
  localparam int CYCLE_LIMIT =
    (WALK_MAX + MIXED_CMDS + GAP_CMDS) * (ddl_pkg::CYC_ZQ_INIT + MAX_GAP + 2) + 500;

  logic                           clock;
  logic                           reset;
  logic                           ctl_req_i;
  logic                           ctl_rdy_o;
  ddl_pkg::cmd_e                  ctl_cmd_i;
  logic [ddl_pkg::BANK_BITS-1:0]  ctl_ba_i;
  logic [ddl_pkg::ROW_BITS-1:0]   ctl_adr_i;
  logic                           mem_wvalid_i;
  logic                           mem_wready_o;
  logic [ddl_pkg::MASK_BITS-1:0]  mem_wrmask_i;
  logic [ddl_pkg::DATA_BITS-1:0]  mem_wrdata_i;
  logic                           mem_rvalid_o;
  logic                           mem_rready_i;
  logic [ddl_pkg::DATA_BITS-1:0]  mem_rddata_o;
  logic                           dfi_ras_no;
  logic                           dfi_cas_no;
  logic                           dfi_we_no;
  logic [ddl_pkg::BANK_BITS-1:0]  dfi_bank_o;
  logic [ddl_pkg::ROW_BITS-1:0]   dfi_addr_o;
  logic                           dfi_wstb_o;
  logic                           dfi_wren_o;
  logic [ddl_pkg::MASK_BITS-1:0]  dfi_mask_o;
  logic [ddl_pkg::DATA_BITS-1:0]  dfi_data_o;
  logic                           dfi_rvld_i;
  logic [ddl_pkg::DATA_BITS-1:0]  dfi_data_i;

  int          test_id;
  logic        test_end;
  int          checks;
  int          errors;
  int          cycles;
  logic [31:0] rng;
  logic [31:0] data_rng;
  // Bank state as the stimulus sees it, I for idle
  byte         bank_st;

  ddr3_ddl i_dut (
    .clock, .reset, .ctl_req_i, .ctl_rdy_o, .ctl_cmd_i, .ctl_ba_i, .ctl_adr_i,
    .mem_wvalid_i, .mem_wready_o, .mem_wrmask_i, .mem_wrdata_i,
    .mem_rvalid_o, .mem_rready_i, .mem_rddata_o,
    .dfi_ras_no, .dfi_cas_no, .dfi_we_no, .dfi_bank_o, .dfi_addr_o,
    .dfi_wstb_o, .dfi_wren_o, .dfi_mask_o, .dfi_data_o, .dfi_rvld_i, .dfi_data_i
  );

  ddl_checker i_chk (
    .clock, .reset, .test_id_i(test_id), .test_end_i(test_end),
    .req_i(ctl_req_i), .rdy_i(ctl_rdy_o), .cmd_i(ctl_cmd_i), .ba_i(ctl_ba_i),
    .adr_i(ctl_adr_i), .wready_i(mem_wready_o), .wrdata_i(mem_wrdata_i),
    .wrmask_i(mem_wrmask_i), .rvalid_i(mem_rvalid_o), .rddata_i(mem_rddata_o),
    .ras_n_i(dfi_ras_no), .cas_n_i(dfi_cas_no), .we_n_i(dfi_we_no),
    .bank_i(dfi_bank_o), .addr_i(dfi_addr_o), .wstb_i(dfi_wstb_o), .wren_i(dfi_wren_o),
    .phy_mask_i(dfi_mask_o), .phy_data_i(dfi_data_o), .phy_rvld_i(dfi_rvld_i),
    .phy_rdata_i(dfi_data_i), .checks_o(checks), .errors_o(errors)
  );

  initial clock = 1'b0;
  always #10 clock = ~clock;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // Commands allowed next, one letter each
  function automatic string legal_next(input byte st);
    case (st)
      "A":     return "RWA";
      "R":     return "RWAP";
      "W":     return "WRAP";
      "P":     return "AF";
      "F":     return "AFP";
      "M":     return "MPFZ";
      "Z":     return "AFP";
      default: return "APFMZ";
    endcase
  endfunction

  function automatic ddl_pkg::cmd_e letter_to_cmd(input byte c);
    case (c)
      "A":     return ddl_pkg::CMD_ACTV;
      "R":     return ddl_pkg::CMD_READ;
      "W":     return ddl_pkg::CMD_WRIT;
      "P":     return ddl_pkg::CMD_PREC;
      "F":     return ddl_pkg::CMD_REFR;
      "M":     return ddl_pkg::CMD_MODE;
      "Z":     return ddl_pkg::CMD_ZQCL;
      default: return ddl_pkg::CMD_NOOP;
    endcase
  endfunction

  // Waits out the hold-off, idles gap cycles, then presents one command
  task automatic send_cmd(input byte letter, input int gap);
    logic [31:0] r;
    while (!ctl_rdy_o) begin
      @(posedge clock);
      #2;
    end
    repeat (gap) begin
      @(posedge clock);
      #2;
    end
    r = next_rand();
    ctl_req_i = 1'b1;
    ctl_cmd_i = letter_to_cmd(letter);
    ctl_ba_i  = r[ddl_pkg::BANK_BITS-1:0];
    ctl_adr_i = r[ddl_pkg::ROW_BITS+15:16];
    @(posedge clock);
    #2;
    ctl_req_i = 1'b0;
    ctl_cmd_i = ddl_pkg::CMD_NOOP;
    bank_st   = letter;
  endtask

  // A dash idles one cycle, which sends the bank back to idle
  task automatic run_walk(input string steps);
    int gap;
    gap = 0;
    for (int i = 0; i < steps.len(); i++) begin
      if (steps[i] == "-") begin
        gap = 1;
      end else begin
        send_cmd(steps[i], gap);
        gap = 0;
      end
    end
  endtask

  task automatic run_random(input int count, input int max_gap);
    logic [31:0] r;
    int          gap;
    string       legal;
    for (int i = 0; i < count; i++) begin
      r   = next_rand();
      gap = (r[3:2] == 2'b00) ? 1 + int'(r[7:4]) % max_gap : 0;
      if (gap > 0) bank_st = "I";
      legal = legal_next(bank_st);
      send_cmd(legal[int'(r[31:16]) % legal.len()], gap);
    end
  endtask

  // Lets hold-off and write windows drain before the test is closed
  task automatic end_test();
    while (!ctl_rdy_o) begin
      @(posedge clock);
      #2;
    end
    repeat (ddl_pkg::WR_LAT + ddl_pkg::BURST_CYC + 2) begin
      @(posedge clock);
      #2;
    end
    test_end = 1'b1;
    @(posedge clock);
    #2;
    test_end = 1'b0;
    test_id  = test_id + 1;
    bank_st  = "I";
  endtask

  // Write and read data traffic, new values every cycle
  always @(posedge clock) begin
    #2;
    data_rng     = xorshift(data_rng);
    mem_wrdata_i = data_rng;
    mem_wrmask_i = data_rng[7:4];
    dfi_data_i   = {data_rng[15:0], data_rng[31:16]};
    dfi_rvld_i   = data_rng[9];
  end

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: run still busy after %0d cycles", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    reset        = 1'b1;
    ctl_req_i    = 1'b0;
    ctl_cmd_i    = ddl_pkg::CMD_NOOP;
    ctl_ba_i     = '0;
    ctl_adr_i    = '0;
    mem_wvalid_i = 1'b1;
    mem_wrmask_i = '0;
    mem_wrdata_i = '0;
    mem_rready_i = 1'b1;
    dfi_rvld_i   = 1'b0;
    dfi_data_i   = '0;
    test_id      = 0;
    test_end     = 1'b0;
    cycles       = 0;
    rng          = SEED;
    data_rng     = SEED ^ 32'h9e37_79b9;
    bank_st      = "I";
    repeat (3) @(posedge clock);
    #2;
    reset = 1'b0;

    end_test();
    // Covers every legal pair of the bank-state table
    run_walk("MMZAARRWWRAWARPAWPFFA-ZFP-MP-MF-ZP-A-P-F");
    end_test();
    run_random(MIXED_CMDS, 3);
    end_test();
    run_random(GAP_CMDS, MAX_GAP);
    end_test();

    $display("tests %0d, checks %0d, errors %0d", test_id, checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* ddr3_ddl.f */
design/ddl_pkg.sv
design/ddl_cmd_issue.sv
design/ddl_write_path.sv
design/ddr3_ddl.sv
tb/ddl_checker.sv
tb/tb_ddl.sv

/* Makefile */
# Verilator build and run of the DDR3 data-link layer testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f ddr3_ddl.f --top-module tb_ddl -o sim_ddl

# Passes only when the simulation prints the pass message
run: compile
	@out="$$(./obj_dir/sim_ddl)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir
